// File: src.f
+incdir+design
design/bcd_time_pkg.sv
design/watch_mode_pkg.sv
design/tick_gen.sv
design/mmss_counter.sv
design/mode_fsm.sv
design/alarm_unit.sv
design/display_scan.sv
design/watch_top.sv
bench/watch_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --timing --timescale 1ns/100ps
TOP   = watch_tb
FLIST = src.f
OBJ   = obj_dir
PASS  = TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ)

// File: bench/watch_tb.sv
`include "watch_consts.svh"

module watch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int sec_div   = 20;
  localparam int scan_div  = 2;
  localparam int show_time = 0;
  localparam int show_stw  = 1;
  localparam int show_alm  = 2;
  localparam int show_set  = 3;
  localparam logic [2:0] func_time = 3'b100;
  localparam logic [2:0] func_stw  = 3'b010;
  localparam logic [2:0] func_alm  = 3'b001;

  typedef struct packed {
    int          btn;       // 0 none, 1 mode, 2 switch
    int          secs;      // whole seconds to wait after the press
    int          disp;      // expected mm:ss as seconds of the hour
    logic [2:0]  func_led;
    logic        armed;
    logic [11:0] ring;
  } entry_t;

  logic        clk;
  logic        rst;
  logic        mode;
  logic        switch;
  logic [6:0]  segs;
  logic [3:0]  ssd_ctl;
  logic [15:0] led;

  entry_t tbl[$];
  int     cyc = -1;         // clk edges since reset release
  int     errors = 0;
  int     tm;               // reference model of the watch
  int     stw;
  int     alm;
  int     set_m;
  int     set_s;
  bit     stw_on;
  bit     armed;

  watch_top #(.sec_div(sec_div), .scan_div(scan_div)) i_watch_top (
    .clk(clk), .rst(rst), .mode(mode), .switch(switch),
    .segs(segs), .ssd_ctl(ssd_ctl), .led(led)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    if (rst)
      cyc <= -1;
    else
      cyc <= cyc + 1;
  end

  function automatic logic [3:0] seg_digit(input logic [6:0] s);
    case (s)
      7'b0000001:       return 4'd0;
      7'b1001111:       return 4'd1;
      7'b0010010:       return 4'd2;
      7'b0000110:       return 4'd3;
      7'b1001100:       return 4'd4;
      7'b0100100:       return 4'd5;
      7'b0100000:       return 4'd6;
      7'b0001111:       return 4'd7;
      7'b0000000:       return 4'd8;
      7'b0000100:       return 4'd9;
      `WATCH_SEG_BLANK: return 4'hf;
      default:          return 4'he;  // no known pattern
    endcase
  endfunction

  function automatic logic [15:0] to_bcd(input int v);
    int m;
    int s;
    m = v / 60;
    s = v % 60;
    return {4'(m / 10), 4'(m % 10), 4'(s / 10), 4'(s % 10)};
  endfunction

  // ring pattern d seconds after time met the alarm
  function automatic logic [11:0] expected_ring();
    int d;
    d = (tm - alm + 3600) % 3600;
    if (!armed || d < 1 || d > `WATCH_RING_SECS)
      return 12'h000;
    return (d % 2 == 1) ? 12'h0f0 : 12'hf0f;
  endfunction

  task automatic pass_secs(input int n);
    tm = (tm + n) % 3600;
    if (stw_on)
      stw = (stw + n) % 3600;
  endtask

  task automatic add_entry(input int btn, input int secs, input int shown,
                           input logic [2:0] fl);
    entry_t e;
    pass_secs(secs);
    e.btn  = btn;
    e.secs = secs;
    case (shown)
      show_time: e.disp = tm;
      show_stw:  e.disp = stw;
      show_alm:  e.disp = alm;
      default:   e.disp = set_m * 60 + set_s;
    endcase
    e.func_led = fl;
    e.armed    = armed;
    e.ring     = expected_ring();
    tbl.push_back(e);
    pass_secs(1);  // next entry starts on the following second
  endtask

  task automatic load_set(input int v);
    set_m = v / 60;
    set_s = v % 60;
  endtask

  // minute steps, mode, then second steps from SETMIN
  task automatic edit_setting(input int mins, input int secs, input logic [2:0] fl);
    repeat (mins)
    begin
      set_m = (set_m + 1) % 60;
      add_entry(2, 0, show_set, fl);
    end
    add_entry(1, 0, show_set, fl);
    repeat (secs)
    begin
      set_s = (set_s + 1) % 60;
      add_entry(2, 0, show_set, fl);
    end
  endtask

  task automatic build_table();
    int target;
    tm     = 0;
    stw    = 0;
    alm    = 0;
    stw_on = 0;
    armed  = 0;
    pass_secs(1);
    add_entry(0, 3, show_time, func_time);
    load_set(tm);
    add_entry(2, 0, show_set, func_time);             // TIME_SETMIN
    edit_setting($urandom % 4 + 1, 3, func_time);
    tm = set_m * 60 + set_s;
    add_entry(1, 0, show_time, func_time);            // commit
    add_entry(0, 2, show_time, func_time);
    load_set(tm);
    add_entry(2, 0, show_set, func_time);
    edit_setting((59 - set_m + 60) % 60, (58 - set_s + 60) % 60, func_time);
    tm = set_m * 60 + set_s;
    add_entry(1, 0, show_time, func_time);            // 59:58
    add_entry(0, 2, show_time, func_time);            // wraps to 00:01
    add_entry(1, 0, show_stw, func_stw);
    stw_on = 1;
    add_entry(2, 3, show_stw, func_stw);              // start
    stw_on = 0;
    add_entry(2, 0, show_stw, func_stw);              // pause
    add_entry(0, 3, show_stw, func_stw);              // frozen
    stw_on = 1;
    add_entry(2, 2, show_stw, func_stw);              // resume
    stw_on = 0;
    add_entry(2, 0, show_stw, func_stw);
    load_set(stw);
    add_entry(1, 0, show_set, func_stw);              // STW_SETMIN
    edit_setting(1, 1, func_stw);
    stw = set_m * 60 + set_s;
    add_entry(1, 0, show_stw, func_stw);
    add_entry(1, 0, show_alm, func_alm);              // ALM_DISP
    load_set(alm);
    add_entry(2, 0, show_set, func_alm);
    target = (tm + 130) % 3600;  // past the end of the edit
    edit_setting(target / 60, target % 60, func_alm);
    alm   = set_m * 60 + set_s;
    armed = 1;
    add_entry(1, 0, show_alm, func_alm);              // commit arms
    add_entry(1, 0, show_time, func_time);
    add_entry(0, (alm - tm + 3600) % 3600 - 2, show_time, func_time);
    repeat (`WATCH_RING_SECS + 3)
      add_entry(0, 0, show_time, func_time);          // through the ring
  endtask

  task automatic next_second();
    do
    begin
      @(posedge clk);
      #1;
    end
    while (cyc % sec_div != 0 || cyc <= 0);
  endtask

  // one and a half scan rotations sampled mid cycle
  task automatic read_display(output logic [15:0] got);
    int pos;
    int prev;
    prev = -1;
    got  = 16'heeee;
    repeat (6 * scan_div)
    begin
      @(negedge clk);
      case (ssd_ctl)
        4'b1110: pos = 0;
        4'b1101: pos = 1;
        4'b1011: pos = 2;
        4'b0111: pos = 3;
        default: pos = -1;
      endcase
      if (pos < 0)
      begin
        errors++;
        $display("FAIL ssd_ctl: got %h, expected one low bit", ssd_ctl);
      end
      else
      begin
        if (prev >= 0 && pos != prev && pos != (prev + 1) % 4)
        begin
          errors++;
          $display("scan order wrong, digit %0d came after digit %0d", pos, prev);
        end
        got[pos*4 +: 4] = seg_digit(segs);
        prev = pos;
      end
    end
  endtask

  task automatic check_entry(input entry_t e);
    logic [15:0] got;
    logic [15:0] exp;
    read_display(got);
    exp = to_bcd(e.disp);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL segs: got %h, expected %h", got, exp);
    end
    if (led[15:13] !== e.func_led)
    begin
      errors++;
      $display("FAIL led[15:13]: got %h, expected %h", led[15:13], e.func_led);
    end
    if (led[12] !== e.armed)
    begin
      errors++;
      $display("FAIL led[12]: got %h, expected %h", led[12], e.armed);
    end
    if (led[11:0] !== e.ring)
    begin
      errors++;
      $display("FAIL led[11:0]: got %h, expected %h", led[11:0], e.ring);
    end
  endtask

  task automatic timeout_guard(input int secs);
    #((secs + 2) * sec_div * 10 + 1000);
    $display("timeout, the stimulus table did not complete in time");
    $display("TESTS FAILED");
    $finish;
  endtask

  initial
  begin
    entry_t e0;
    int     total;
    clk    = 1'b0;
    rst    = 1'b1;
    mode   = 1'b0;
    switch = 1'b0;
    void'($urandom(32'h6a8311e6));
    build_table();
    total = 0;
    foreach (tbl[i])
      total += tbl[i].secs + 1;
    fork
      timeout_guard(total);
    join_none
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    e0 = '0;
    e0.func_led = func_time;
    check_entry(e0);                 // 00:00 straight out of reset
    foreach (tbl[i])
    begin
      next_second();
      mode   = (tbl[i].btn == 1);
      switch = (tbl[i].btn == 2);
      @(posedge clk);
      #1;
      mode   = 1'b0;
      switch = 1'b0;
      if (tbl[i].secs == 0)
        repeat (2) @(posedge clk);   // let the load land
      else
        repeat (tbl[i].secs) next_second();
      check_entry(tbl[i]);
    end
    $display("%0d entries checked, %0d errors", tbl.size() + 1, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: design/watch_top.sv
`include "watch_consts.svh"

module watch_top import bcd_time_pkg::*, watch_mode_pkg::*; #(
  parameter int unsigned sec_div  = `WATCH_SEC_DIV,
  parameter int unsigned scan_div = `WATCH_SCAN_DIV
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        mode,
  input  logic        switch,
  output logic [6:0]  segs,
  output logic [3:0]  ssd_ctl,
  output logic [15:0] led       // {time, stw, alm, armed, ring[11:0]}
);

  logic        sec_tick;
  logic        scan_tick;
  state_u      state;
  logic        set_load;
  logic        set_inc_min;
  logic        set_inc_sec;
  logic        commit;
  logic        stw_run;
  logic        alm_arm;
  logic        time_load;
  logic        stw_load;
  logic        alm_load;
  mmss_t       time_value;
  mmss_t       stw_value;
  mmss_t       alarm_value;
  mmss_t       set_value;
  mmss_t       set_src;
  mmss_t       disp_value;
  logic [11:0] ring_led;

  tick_gen #(.sec_div(sec_div), .scan_div(scan_div)) u_tick (
    .clk(clk), .rst(rst), .sec_tick(sec_tick), .scan_tick(scan_tick)
  );

  mode_fsm u_fsm (
    .clk(clk), .rst(rst), .mode(mode), .switch(switch), .state(state),
    .set_load(set_load), .set_inc_min(set_inc_min), .set_inc_sec(set_inc_sec),
    .commit(commit), .stw_run(stw_run), .alm_arm(alm_arm)
  );

  // commit goes back to the function being edited
  assign time_load = commit && (state.f.func == TIME);
  assign stw_load  = commit && (state.f.func == STW);
  assign alm_load  = commit && (state.f.func == ALM);

  mmss_counter u_time (
    .clk(clk), .rst(rst), .count(sec_tick), .inc_min(1'b0), .inc_sec(1'b0),
    .load(time_load), .load_value(set_value), .value(time_value)
  );

  mmss_counter u_stw (
    .clk(clk), .rst(rst), .count(sec_tick && stw_run), .inc_min(1'b0), .inc_sec(1'b0),
    .load(stw_load), .load_value(set_value), .value(stw_value)
  );

  mmss_counter u_set (
    .clk(clk), .rst(rst), .count(1'b0), .inc_min(set_inc_min), .inc_sec(set_inc_sec),
    .load(set_load), .load_value(set_src), .value(set_value)
  );

  alarm_unit u_alarm (
    .clk(clk), .rst(rst), .sec_tick(sec_tick), .load(alm_load), .load_value(set_value),
    .time_value(time_value), .arm(alm_arm), .alarm_value(alarm_value), .ringing(),
    .ring_led(ring_led)
  );

  // setting register source
  always_comb
  begin
    case (state.f.func)
      TIME:    set_src = time_value;
      STW:     set_src = stw_value;
      ALM:     set_src = alarm_value;
      default: set_src = '0;
    endcase
  end

  // what the digits show
  always_comb
  begin
    case (state.code)
      STW_DISP, STW_START, STW_PAUSE: disp_value = stw_value;
      ALM_DISP:                       disp_value = alarm_value;
      TIME_SETMIN, TIME_SETSEC,
      STW_SETMIN, STW_SETSEC,
      ALM_SETMIN, ALM_SETSEC:         disp_value = set_value;  // value being edited
      default:                        disp_value = time_value;
    endcase
  end

  display_scan u_disp (
    .clk(clk), .rst(rst), .scan_tick(scan_tick), .value(disp_value),
    .segs(segs), .ssd_ctl(ssd_ctl)
  );

  assign led = {state.f.func == TIME, state.f.func == STW, state.f.func == ALM,
                alm_arm, ring_led};

endmodule

// File: design/display_scan.sv
`include "watch_consts.svh"

module display_scan import bcd_time_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       scan_tick,
  input  mmss_t      value,
  output logic [6:0] segs,     // active low, a in bit 6
  output logic [3:0] ssd_ctl   // active low, bit 0 is sec0
);

  logic [1:0] idx;             // digit currently lit
  bcd_digit_t digit;

  always_ff @(posedge clk)
  begin
    if (rst)
      idx <= 2'd0;
    else if (scan_tick)
      idx <= idx + 2'd1;  // wraps 3 -> 0
  end

  assign ssd_ctl = ~(4'b0001 << idx);

  always_comb
  begin
    case (idx)
      2'd0:    digit = value.sec0;
      2'd1:    digit = value.sec1;
      2'd2:    digit = value.min0;
      default: digit = value.min1;
    endcase
  end

  // BCD to segments
  always_comb
  begin
    case (digit)
      4'd0:    segs = `WATCH_SEG_0;
      4'd1:    segs = `WATCH_SEG_1;
      4'd2:    segs = `WATCH_SEG_2;
      4'd3:    segs = `WATCH_SEG_3;
      4'd4:    segs = `WATCH_SEG_4;
      4'd5:    segs = `WATCH_SEG_5;
      4'd6:    segs = `WATCH_SEG_6;
      4'd7:    segs = `WATCH_SEG_7;
      4'd8:    segs = `WATCH_SEG_8;
      4'd9:    segs = `WATCH_SEG_9;
      default: segs = `WATCH_SEG_BLANK;  // not a decimal digit
    endcase
  end

endmodule

// File: design/alarm_unit.sv
`include "watch_consts.svh"

module alarm_unit import bcd_time_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        sec_tick,
  input  logic        load,
  input  mmss_t       load_value,
  input  mmss_t       time_value,
  input  logic        arm,
  output mmss_t       alarm_value,
  output logic        ringing,
  output logic [11:0] ring_led
);

  localparam int rw = $clog2(`WATCH_RING_SECS + 1);

  logic [rw-1:0] ring_cnt;  // seconds left to ring
  logic          match;

  assign match = arm && (time_value == alarm_value);

  always_ff @(posedge clk)
  begin
    if (rst)
      alarm_value <= '0;
    else if (load)
      alarm_value <= load_value;
  end

  always_ff @(posedge clk)
  begin
    if (rst || !arm)
    begin
      ringing  <= 1'b0;
      ring_cnt <= '0;
      ring_led <= '0;
    end
    else if (sec_tick)
    begin
      if (ringing)
      begin
        if (ring_cnt == '0)
        begin
          ringing  <= 1'b0;
          ring_led <= '0;
        end
        else
        begin
          ring_cnt <= ring_cnt - 1'b1;
          ring_led <= ~ring_led;  // 0x0F0 <-> 0xF0F
        end
      end
      else if (match)
      begin
        ringing  <= 1'b1;
        ring_cnt <= rw'(`WATCH_RING_SECS - 1);
        ring_led <= 12'h0f0;
      end
    end
  end

endmodule

// File: design/mode_fsm.sv
module mode_fsm import watch_mode_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   mode,         // mode button level
  input  logic   switch,       // switch button level
  output state_u state,
  output logic   set_load,     // copy selected function into setting register
  output logic   set_inc_min,
  output logic   set_inc_sec,
  output logic   commit,       // write setting register back
  output logic   stw_run,
  output logic   alm_arm
);

  logic mode_q;
  logic switch_q;
  logic mode_press;
  logic switch_press;

  // one press per rising level, holding does nothing more
  assign mode_press   = mode && !mode_q;
  assign switch_press = switch && !switch_q;

  assign stw_run = (state.code == STW_START);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mode_q      <= 1'b0;
      switch_q    <= 1'b0;
      state.code  <= TIME_DISP;
      set_load    <= 1'b0;
      set_inc_min <= 1'b0;
      set_inc_sec <= 1'b0;
      commit      <= 1'b0;
      alm_arm     <= 1'b0;
    end
    else
    begin
      mode_q      <= mode;
      switch_q    <= switch;
      set_load    <= 1'b0;  // pulses by default
      set_inc_min <= 1'b0;
      set_inc_sec <= 1'b0;
      commit      <= 1'b0;

      case (state.code)
        TIME_DISP:
          if (mode_press)
            state.code <= STW_DISP;
          else if (switch_press)
          begin
            state.code <= TIME_SETMIN;
            set_load   <= 1'b1;
          end
        STW_DISP:
          if (mode_press)
            state.code <= ALM_DISP;
          else if (switch_press)
            state.code <= STW_START;
        STW_START:
          if (switch_press)
            state.code <= STW_PAUSE;  // mode ignored while running
        STW_PAUSE:
          if (mode_press)
          begin
            state.code <= STW_SETMIN;
            set_load   <= 1'b1;
          end
          else if (switch_press)
            state.code <= STW_START;
        ALM_DISP:
          if (mode_press)
            state.code <= TIME_DISP;
          else if (switch_press)
          begin
            state.code <= ALM_SETMIN;
            set_load   <= 1'b1;
            alm_arm    <= 1'b0;  // disarmed while editing
          end
        TIME_SETMIN, STW_SETMIN, ALM_SETMIN:
          if (mode_press)
            state.f.step <= SETSEC;
          else if (switch_press)
            set_inc_min <= 1'b1;
        TIME_SETSEC, STW_SETSEC, ALM_SETSEC:
          if (mode_press)
          begin
            state.f.step <= DISP;
            commit       <= 1'b1;
            if (state.f.func == ALM)
              alm_arm <= 1'b1;
          end
          else if (switch_press)
            set_inc_sec <= 1'b1;
        default:
          state.code <= TIME_DISP;  // recover from an unused code
      endcase
    end
  end

endmodule

// File: design/mmss_counter.sv
module mmss_counter import bcd_time_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  count,       // advance one second, carry into minutes
  input  logic  inc_min,     // step minutes only
  input  logic  inc_sec,     // step seconds only
  input  logic  load,
  input  mmss_t load_value,
  output mmss_t value
);

  logic [7:0] sec_next;
  logic [7:0] min_next;
  logic       sec_wrap;      // seconds at 59
  logic       step_sec;
  logic       step_min;

  assign sec_next = inc_mod60(value.sec1, value.sec0);
  assign min_next = inc_mod60(value.min1, value.min0);
  assign sec_wrap = (value.sec1 == 4'd5) && (value.sec0 == 4'd9);

  // a plain second step never touches minutes unless it wraps
  assign step_sec = count || inc_sec;
  assign step_min = (count && sec_wrap) || inc_min;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      value <= '0;
    end
    else if (load)
    begin
      value <= load_value;  // load wins over counting
    end
    else
    begin
      if (step_sec)
      begin
        value.sec1 <= sec_next[7:4];
        value.sec0 <= sec_next[3:0];
      end
      if (step_min)
      begin
        value.min1 <= min_next[7:4];  // 59:59 rolls to 00:00
        value.min0 <= min_next[3:0];
      end
    end
  end

endmodule

// File: design/tick_gen.sv
`include "watch_consts.svh"

module tick_gen #(
  parameter int unsigned sec_div  = `WATCH_SEC_DIV,  // at least 2
  parameter int unsigned scan_div = `WATCH_SCAN_DIV  // at least 2
) (
  input  logic clk,
  input  logic rst,
  output logic sec_tick,   // one clk every second
  output logic scan_tick   // one clk every digit step
);

  logic [1:0] ticks;

  // the two dividers only differ in their period
  for (genvar i = 0; i < 2; i++)
  begin : g_div
    localparam int unsigned div = (i == 0) ? sec_div : scan_div;
    localparam int cw = $clog2(div);

    logic [cw-1:0] cnt;  // counts down to 0
    logic          tick;

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        cnt  <= cw'(div - 1);
        tick <= 1'b0;
      end
      else if (cnt == '0)
      begin
        cnt  <= cw'(div - 1);  // reload on terminal count
        tick <= 1'b1;
      end
      else
      begin
        cnt  <= cnt - 1'b1;
        tick <= 1'b0;
      end
    end

    assign ticks[i] = tick;
  end

  assign sec_tick  = ticks[0];
  assign scan_tick = ticks[1];

endmodule

// File: design/watch_mode_pkg.sv
package watch_mode_pkg;

  // which function the watch is showing
  typedef enum logic [1:0] {
    TIME = 2'd0,
    STW  = 2'd1,
    ALM  = 2'd2
  } func_t;

  // where inside the function we are
  typedef enum logic [2:0] {
    DISP   = 3'd0,
    SETMIN = 3'd1,
    SETSEC = 3'd2,
    START  = 3'd3,
    PAUSE  = 3'd4
  } step_t;

  // full state codes, each one is {func, step}
  typedef enum logic [4:0] {
    TIME_DISP   = {TIME, DISP},
    TIME_SETMIN = {TIME, SETMIN},
    TIME_SETSEC = {TIME, SETSEC},
    STW_DISP    = {STW, DISP},
    STW_SETMIN  = {STW, SETMIN},
    STW_SETSEC  = {STW, SETSEC},
    STW_START   = {STW, START},
    STW_PAUSE   = {STW, PAUSE},
    ALM_DISP    = {ALM, DISP},
    ALM_SETMIN  = {ALM, SETMIN},
    ALM_SETSEC  = {ALM, SETSEC}
  } state_code_t;

  typedef struct packed {
    func_t func;
    step_t step;
  } state_f_t;

  // state word, read either as one code or as its two fields
  typedef union packed {
    state_code_t code;
    state_f_t    f;
  } state_u;

endpackage

// File: design/bcd_time_pkg.sv
package bcd_time_pkg;

  // one decimal digit
  typedef logic [3:0] bcd_digit_t;

  // minutes:seconds as four digits, min1 in the top nibble
  typedef struct packed {
    bcd_digit_t min1;  // tens of minutes
    bcd_digit_t min0;  // units of minutes
    bcd_digit_t sec1;  // tens of seconds
    bcd_digit_t sec0;  // units of seconds
  } mmss_t;

  // a decimal pair counting 00..59
  function automatic logic [7:0] inc_mod60(input bcd_digit_t tens, input bcd_digit_t ones);
    bcd_digit_t t;
    bcd_digit_t o;
    t = tens;
    o = ones + 4'd1;
    if (ones == 4'd9)
    begin
      o = 4'd0;
      t = (tens == 4'd5) ? 4'd0 : tens + 4'd1;
    end
    return {t, o};
  endfunction

endpackage

// File: design/watch_consts.svh
`ifndef WATCH_CONSTS_SVH
`define WATCH_CONSTS_SVH

// clock enables for a 100 MHz board clock
`define WATCH_SEC_DIV   100000000  // clk cycles per second tick
`define WATCH_SCAN_DIV  50000      // clk cycles per digit step

`define WATCH_RING_SECS 5          // alarm ring length in seconds

// 7-segment patterns, bit 6 is segment a, bit 0 is segment g, active low
`define WATCH_SEG_0     7'b0000001
`define WATCH_SEG_1     7'b1001111
`define WATCH_SEG_2     7'b0010010
`define WATCH_SEG_3     7'b0000110
`define WATCH_SEG_4     7'b1001100
`define WATCH_SEG_5     7'b0100100
`define WATCH_SEG_6     7'b0100000
`define WATCH_SEG_7     7'b0001111
`define WATCH_SEG_8     7'b0000000
`define WATCH_SEG_9     7'b0000100
`define WATCH_SEG_BLANK 7'b1111111  // all segments off

`endif
